/* rtl/mips_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, opcodes and APB map of the core
// included by the RTL and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define DATA_W        32
`define REG_ADDR_W    5
`define IMEM_DEPTH    64
`define DMEM_DEPTH    64
`define IMEM_ADDR_W   6

`define OP_RTYPE      6'h00
`define OP_ADDI       6'h08
`define OP_LW         6'h23
`define OP_SW         6'h2b
`define OP_BEQ        6'h04
`define OP_BNE        6'h05
`define OP_HALT       6'h3f

`define FN_ADD        6'h20
`define FN_SUB        6'h22
`define FN_AND        6'h24
`define FN_OR         6'h25
`define FN_SLT        6'h2a

`define APB_ADDR_W    12
`define APB_IMEM_BASE 12'h000
`define APB_REG_BASE  12'h800
`define APB_CTRL_ADDR 12'hC00

`endif

/* rtl/mips_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction, pipeline and APB types
// imported by every unit of the core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mips_macros.svh"

package mips_pkg;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } i_fields_t;

    // one word read as R fields for rd/funct or I fields for the immediate
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic valid;        // 0 marks a bubble
        logic reg_write;
        logic mem_to_reg;
        logic mem_read;
        logic mem_write;
        logic alu_src_imm;
        logic dest_rd;      // rd for R-type, rt otherwise
        logic is_branch;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`DATA_W-1:0]     a;
        logic [`DATA_W-1:0]     b;
        logic [`DATA_W-1:0]     imm;
        logic [5:0]             funct;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   is_load;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`DATA_W-1:0]     alu_result;
        logic [`DATA_W-1:0]     store_data;
        logic [`REG_ADDR_W-1:0] dest;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`DATA_W-1:0]     alu_result;
        logic [`DATA_W-1:0]     load_data;
        logic [`REG_ADDR_W-1:0] dest;
    } mem_wb_t;

    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`DATA_W-1:0]     data;
    } wb_t;

    typedef struct packed {
        logic [`APB_ADDR_W-1:0] paddr;
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`DATA_W-1:0]     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`DATA_W-1:0]     prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

endpackage

/* rtl/apb_host_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zero-wait APB slave for program load,
// run control, status and register read-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_macros.svh"

module apb_host_port import mips_pkg::*; (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  apb_req_t                apb_req,
    output apb_rsp_t                apb_rsp,
    output logic                    imem_we,
    output logic [`IMEM_ADDR_W-1:0] imem_idx,
    output logic [`DATA_W-1:0]      imem_word,
    output logic                    start,
    output logic                    run,
    input  logic                    halted,
    output logic [`REG_ADDR_W-1:0]  dbg_idx,
    input  logic [`DATA_W-1:0]      dbg_data
);
    localparam logic [`APB_ADDR_W-1:0] IMEM_BASE = `APB_IMEM_BASE;
    localparam logic [`APB_ADDR_W-1:0] REG_BASE  = `APB_REG_BASE;
    localparam logic [`APB_ADDR_W-1:0] CTRL_ADDR = `APB_CTRL_ADDR;
    localparam int IMEM_LSB = `IMEM_ADDR_W + 2;   // byte window of the imem
    localparam int REG_LSB  = `REG_ADDR_W + 2;

    logic access;
    logic wr;
    logic imem_hit;
    logic reg_hit;
    logic ctrl_hit;

    assign access   = apb_req.psel && apb_req.penable;   // second phase of a transfer
    assign wr       = access && apb_req.pwrite;
    assign imem_hit = apb_req.paddr[`APB_ADDR_W-1:IMEM_LSB] == IMEM_BASE[`APB_ADDR_W-1:IMEM_LSB];
    assign reg_hit  = apb_req.paddr[`APB_ADDR_W-1:REG_LSB] == REG_BASE[`APB_ADDR_W-1:REG_LSB];
    assign ctrl_hit = apb_req.paddr == CTRL_ADDR;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            run <= 1'b0;
        else if (wr && ctrl_hit)
            run <= apb_req.pwdata[0];
    end

    assign start     = wr && ctrl_hit && apb_req.pwdata[0] && !run;   // only from stopped
    assign imem_we   = wr && imem_hit && !run;
    assign imem_idx  = apb_req.paddr[IMEM_LSB-1:2];
    assign imem_word = apb_req.pwdata;
    assign dbg_idx   = apb_req.paddr[REG_LSB-1:2];

    always_comb
    begin
        apb_rsp.pready  = access;
        apb_rsp.pslverr = access && (!(imem_hit || reg_hit || ctrl_hit)
                                     || (wr && imem_hit && run)   // program is locked
                                     || (wr && reg_hit));         // window is read only
        apb_rsp.prdata  = '0;
        if (access && !apb_req.pwrite)
        begin
            if (reg_hit)
                apb_rsp.prdata = dbg_data;
            else if (ctrl_hit)
                apb_rsp.prdata = {{(`DATA_W-2){1'b0}}, halted, run};
        end
    end

endmodule

/* rtl/fetch_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC and instruction memory of the core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_macros.svh"

module fetch_unit import mips_pkg::*; (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  logic                    imem_we,
    input  logic [`IMEM_ADDR_W-1:0] imem_idx,
    input  logic [`DATA_W-1:0]      imem_word,
    input  logic                    start,
    input  logic                    run,
    input  logic                    stall,
    input  logic                    branch_taken,
    input  logic [`DATA_W-1:0]      branch_target,
    input  logic                    halt_seen,
    output logic                    halted,
    output instr_u                  if_instr,
    output logic [`DATA_W-1:0]      if_pc
);
    logic [`DATA_W-1:0] imem [`IMEM_DEPTH];
    logic [`DATA_W-1:0] pc;
    logic               advance;

    assign advance = run && !halted && !halt_seen && !stall;

    always_ff @(posedge SYS_clk)
    begin
        if (imem_we)
            imem[imem_idx] <= imem_word;   // host loads only while stopped
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || start)
        begin
            pc     <= '0;
            halted <= 1'b0;
        end
        else
        begin
            if (halt_seen)
                halted <= 1'b1;
            if (branch_taken)              // already qualified by stall in decode
                pc <= branch_target;
            else if (advance)
                pc <= pc + `DATA_W'd4;
        end
    end

    // a zero word is a bubble for decode
    assign if_instr = (run && !halted) ? instr_u'(imem[pc[`IMEM_ADDR_W+1:2]]) : '0;
    assign if_pc    = pc;

endmodule

/* rtl/decode_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IF/ID register, control decode, register
// file and branch resolution
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_macros.svh"

module decode_unit import mips_pkg::*; (
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic                   start,
    input  logic                   stall,
    input  instr_u                 if_instr,
    input  logic [`DATA_W-1:0]     if_pc,
    input  logic                   fwd_a,
    input  logic                   fwd_b,
    input  logic [`DATA_W-1:0]     mem_result,
    input  wb_t                    wb,
    input  logic [`REG_ADDR_W-1:0] dbg_idx,
    output logic [`DATA_W-1:0]     dbg_data,
    output instr_u                 id_instr,
    output id_ex_t                 id_ex,
    output logic                   branch_taken,
    output logic [`DATA_W-1:0]     branch_target,
    output logic                   halt_seen
);
    logic [`DATA_W-1:0] regs [2**`REG_ADDR_W];
    logic [`DATA_W-1:0] id_pc;
    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] imm_ext;
    ctrl_t              ctrl;

    // write-first read with r0 hardwired to zero
    function automatic logic [`DATA_W-1:0] rf_read(input logic [`REG_ADDR_W-1:0] idx);
        if (idx == '0)
            return '0;
        if (wb.we && wb.dest == idx)
            return wb.data;
        return regs[idx];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || start)
            id_instr <= '0;
        else if (stall)
            id_instr <= id_instr;              // hold behind the producer
        else if (branch_taken || halt_seen)
            id_instr <= '0;                    // squash the word behind
        else
        begin
            id_instr <= if_instr;
            id_pc    <= if_pc;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (wb.we && wb.dest != '0)
            regs[wb.dest] <= wb.data;
    end

    always_comb
    begin
        ctrl = '0;
        case (id_instr.r.opcode)
            `OP_RTYPE: {ctrl.valid, ctrl.reg_write, ctrl.dest_rd} = 3'b111;
            `OP_ADDI:  {ctrl.valid, ctrl.reg_write, ctrl.alu_src_imm} = 3'b111;
            `OP_LW:
            begin
                {ctrl.valid, ctrl.reg_write, ctrl.alu_src_imm} = 3'b111;
                {ctrl.mem_read, ctrl.mem_to_reg} = 2'b11;
            end
            `OP_SW:    {ctrl.valid, ctrl.mem_write, ctrl.alu_src_imm} = 3'b111;
            `OP_BEQ,
            `OP_BNE:   {ctrl.valid, ctrl.is_branch} = 2'b11;
            default:   ctrl = '0;                // halt and unknown words do nothing
        endcase
        if (id_instr == '0)
            ctrl = '0;                           // bubble
    end

    always_comb
    begin
        op_a     = fwd_a ? mem_result : rf_read(id_instr.r.rs);
        op_b     = fwd_b ? mem_result : rf_read(id_instr.r.rt);
        dbg_data = rf_read(dbg_idx);
    end

    assign imm_ext   = {{(`DATA_W-16){id_instr.i.imm[15]}}, id_instr.i.imm};
    assign halt_seen = id_instr.r.opcode == `OP_HALT;

    // beq takes on equal, bne on not equal
    assign branch_taken  = ctrl.is_branch && !stall
                           && ((id_instr.r.opcode == `OP_BEQ) == (op_a == op_b));
    assign branch_target = id_pc + `DATA_W'd4 + (imm_ext << 2);

    always_comb
    begin
        id_ex.ctrl    = ctrl;
        id_ex.a       = op_a;
        id_ex.b       = op_b;
        id_ex.imm     = imm_ext;
        id_ex.funct   = id_instr.r.funct;
        id_ex.dest    = ctrl.dest_rd ? id_instr.r.rd : id_instr.i.rt;
        id_ex.is_load = ctrl.mem_read;
    end

endmodule

/* rtl/hazard_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stall counter and MEM-to-decode forward
// selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_macros.svh"

module hazard_unit import mips_pkg::*; (
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  logic    start,
    input  instr_u  id_instr,
    input  id_ex_t  id_ex,
    input  ex_mem_t ex_mem,
    output logic    stall,
    output logic    fwd_a,
    output logic    fwd_b
);
    logic                   stall_cnt;
    ctrl_t                  mem_ctrl;     // tag of the word now in memory
    logic [`REG_ADDR_W-1:0] mem_dest;
    logic                   uses_rt;
    logic                   hit_ex;
    logic                   mem_alu;

    function automatic logic src_match(input logic [`REG_ADDR_W-1:0] dst,
                                       input logic                   rt_used);
        return dst != '0 && (dst == id_instr.r.rs || (rt_used && dst == id_instr.r.rt));
    endfunction

    always_comb
    begin
        uses_rt = id_ex.ctrl.dest_rd || id_ex.ctrl.is_branch || id_ex.ctrl.mem_write;
        hit_ex  = id_ex.ctrl.valid && ex_mem.ctrl.valid && ex_mem.ctrl.reg_write
                  && src_match(ex_mem.dest, uses_rt);
        stall   = stall_cnt || hit_ex;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || start)
            stall_cnt <= 1'b0;
        else if (stall_cnt)
            stall_cnt <= 1'b0;
        else if (hit_ex && ex_mem.ctrl.mem_read)
            stall_cnt <= 1'b1;                   // second cycle behind a load
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || start)
            mem_ctrl <= '0;
        else
        begin
            mem_ctrl <= ex_mem.ctrl;
            mem_dest <= ex_mem.dest;
        end
    end

    assign mem_alu = mem_ctrl.valid && mem_ctrl.reg_write && !mem_ctrl.mem_read
                     && mem_dest != '0;
    assign fwd_a   = mem_alu && mem_dest == id_instr.r.rs;
    assign fwd_b   = mem_alu && mem_dest == id_instr.r.rt;

endmodule

/* rtl/execute_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID/EX register and the ALU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_macros.svh"

module execute_unit import mips_pkg::*; (
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  logic    start,
    input  logic    stall,
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);
    id_ex_t             idex_q;
    alu_op_e            alu_op;
    logic [`DATA_W-1:0] alu_b;
    logic [`DATA_W-1:0] alu_y;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || start || stall)
            idex_q.ctrl <= '0;                   // bubble
        else
            idex_q <= id_ex;
    end

    always_comb
    begin
        alu_op = ALU_ADD;                        // addi, lw, sw address add
        if (idex_q.ctrl.dest_rd && !idex_q.is_load)
        begin
            case (idex_q.funct)
                `FN_SUB: alu_op = ALU_SUB;
                `FN_AND: alu_op = ALU_AND;
                `FN_OR:  alu_op = ALU_OR;
                `FN_SLT: alu_op = ALU_SLT;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    assign alu_b = idex_q.ctrl.alu_src_imm ? idex_q.imm : idex_q.b;

    always_comb
    begin
        case (alu_op)
            ALU_SUB: alu_y = idex_q.a - alu_b;
            ALU_AND: alu_y = idex_q.a & alu_b;
            ALU_OR:  alu_y = idex_q.a | alu_b;
            ALU_SLT: alu_y = {{(`DATA_W-1){1'b0}}, $signed(idex_q.a) < $signed(alu_b)};
            default: alu_y = idex_q.a + alu_b;
        endcase
    end

    always_comb
    begin
        ex_mem.ctrl       = idex_q.ctrl;
        ex_mem.alu_result = alu_y;
        ex_mem.store_data = idex_q.b;
        ex_mem.dest       = idex_q.dest;
    end

endmodule

/* rtl/memwb_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory stage, data memory and writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_macros.svh"

module memwb_unit import mips_pkg::*; (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               start,
    input  ex_mem_t            ex_mem,
    output logic [`DATA_W-1:0] mem_result,
    output wb_t                wb
);
    localparam int DM_AW = $clog2(`DMEM_DEPTH);

    ex_mem_t            exmem_q;
    mem_wb_t            memwb_q;
    logic [`DATA_W-1:0] dmem [`DMEM_DEPTH];
    logic [DM_AW-1:0]   dm_idx;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || start)
            exmem_q.ctrl <= '0;
        else
            exmem_q <= ex_mem;
    end

    assign dm_idx = exmem_q.alu_result[DM_AW+1:2];   // word addressed

    always_ff @(posedge SYS_clk)
    begin
        if (exmem_q.ctrl.valid && exmem_q.ctrl.mem_write)
            dmem[dm_idx] <= exmem_q.store_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || start)
            memwb_q.ctrl <= '0;
        else
        begin
            memwb_q.ctrl       <= exmem_q.ctrl;
            memwb_q.alu_result <= exmem_q.alu_result;
            memwb_q.load_data  <= dmem[dm_idx];
            memwb_q.dest       <= exmem_q.dest;
        end
    end

    assign mem_result = exmem_q.alu_result;          // forward source for decode

    always_comb
    begin
        wb.we   = memwb_q.ctrl.valid && memwb_q.ctrl.reg_write;
        wb.dest = memwb_q.dest;
        wb.data = memwb_q.ctrl.mem_to_reg ? memwb_q.load_data : memwb_q.alu_result;
    end

endmodule

/* rtl/mips_core_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// five-stage MIPS core behind an APB port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_core_top import mips_pkg::*; (
    input  logic     SYS_clk,
    input  logic     SYS_reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);
    logic                   imem_we;
    logic [`IMEM_ADDR_W-1:0] imem_idx;
    logic [`DATA_W-1:0]     imem_word;
    logic                   start;
    logic                   run;
    logic                   halted;
    logic [`REG_ADDR_W-1:0] dbg_idx;
    logic [`DATA_W-1:0]     dbg_data;
    logic                   stall;
    logic                   branch_taken;
    logic [`DATA_W-1:0]     branch_target;
    logic                   halt_seen;
    instr_u                 if_instr;
    logic [`DATA_W-1:0]     if_pc;
    logic                   fwd_a;
    logic                   fwd_b;
    logic [`DATA_W-1:0]     mem_result;
    wb_t                    wb;
    instr_u                 id_instr;
    id_ex_t                 id_ex;
    ex_mem_t                ex_mem;

    apb_host_port apb_host_port_inst (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .imem_we   (imem_we),
        .imem_idx  (imem_idx),
        .imem_word (imem_word),
        .start     (start),
        .run       (run),
        .halted    (halted),
        .dbg_idx   (dbg_idx),
        .dbg_data  (dbg_data)
    );

    fetch_unit fetch_unit_inst (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .imem_we       (imem_we),
        .imem_idx      (imem_idx),
        .imem_word     (imem_word),
        .start         (start),
        .run           (run),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halt_seen     (halt_seen),
        .halted        (halted),
        .if_instr      (if_instr),
        .if_pc         (if_pc)
    );

    decode_unit decode_unit_inst (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .start         (start),
        .stall         (stall),
        .if_instr      (if_instr),
        .if_pc         (if_pc),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_result    (mem_result),
        .wb            (wb),
        .dbg_idx       (dbg_idx),
        .dbg_data      (dbg_data),
        .id_instr      (id_instr),
        .id_ex         (id_ex),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halt_seen     (halt_seen)
    );

    hazard_unit hazard_unit_inst (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .start     (start),
        .id_instr  (id_instr),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .stall     (stall),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b)
    );

    execute_unit execute_unit_inst (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .start     (start),
        .stall     (stall),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem)
    );

    memwb_unit memwb_unit_inst (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .start      (start),
        .ex_mem     (ex_mem),
        .mem_result (mem_result),
        .wb         (wb)
    );

endmodule

/* tb/mips_core_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// assertions on the core, bound to its top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mips_core_properties import mips_pkg::*; (
    input logic     SYS_clk,
    input logic     SYS_reset,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp,
    input logic     start,
    input logic     halted,
    input logic     stall
);
    // zero-wait slave answers only in the access phase
    rsp_in_access: assert property (
        @(posedge SYS_clk) disable iff (SYS_reset)
        (apb_rsp.pready || apb_rsp.pslverr) |-> (apb_req.psel && apb_req.penable))
    else
        $error("APB response raised outside an access cycle");

    halt_sticky: assert property (
        @(posedge SYS_clk) disable iff (SYS_reset)
        ($past(halted) && !halted) |-> ($past(start) || $past(SYS_reset)))
    else
        $error("halted fell without a start");

    // load hazard is the longest hold
    stall_bounded: assert property (
        @(posedge SYS_clk) disable iff (SYS_reset)
        (stall && $past(stall)) |-> !$past(stall, 2))
    else
        $error("stall held for more than two cycles");

endmodule

bind mips_core_top mips_core_properties mips_core_properties_inst (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .start     (start),
    .halted    (halted),
    .stall     (stall)
);

/* tb/tb_mips_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// loads a program into the MIPS core over APB, runs it to halt
// and checks status and registers against the data file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_mips_core import mips_pkg::*; ();
    localparam int HOST_XFERS = 6;   // status, window write, unmapped, start, locked write, final

    logic        SYS_clk;
    logic        SYS_reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] tdata [0:255];
    int          order[$];
    int          prog_len;
    int          n_pairs;
    int          limit = 0;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          pos;
    int          pick;
    int          held;
    int          idx;
    logic [31:0] rdata;
    logic [31:0] status;
    logic        err;

    mips_core_top mips_core_top_inst (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #5 SYS_clk = ~SYS_clk;
    end

    // cycle budget scales with program length and host traffic
    initial
    begin
        wait (limit > 0);
        while (cycles < limit)
        begin
            @(posedge SYS_clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("Errors found");
        $finish;
    end

    function automatic logic [31:0] word_at(input int p);
        return tdata[8'(p)];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic apb_transfer(input string name, input logic [11:0] addr,
                                input logic write, input logic [31:0] wdata,
                                output logic [31:0] rd, output logic slverr);
        @(posedge SYS_clk);
        apb_req.paddr   <= addr;   // setup phase
        apb_req.pwrite  <= write;
        apb_req.pwdata  <= wdata;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge SYS_clk);
        apb_req.penable <= 1'b1;   // access phase
        @(negedge SYS_clk);
        rd     = apb_rsp.prdata;   // settled mid access cycle
        slverr = apb_rsp.pslverr;
        check_value({name, " pready"}, 32'd1, 32'(apb_rsp.pready));
        @(posedge SYS_clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic write_word(input string name, input logic [11:0] addr,
                              input logic [31:0] data, input logic exp_err);
        logic [31:0] unused_rd;
        logic        slverr;
        apb_transfer(name, addr, 1'b1, data, unused_rd, slverr);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(slverr));
    endtask

    initial
    begin
        apb_req   = '0;
        SYS_reset = 1'b1;
        void'($urandom(49));
        $readmemh("tb/core_testdata.txt", tdata);
        prog_len = word_at(0);
        n_pairs  = word_at(prog_len + 1);
        limit    = 20 * prog_len + 2 * (prog_len + n_pairs + HOST_XFERS);
        repeat (2) @(posedge SYS_clk);
        SYS_reset <= 1'b0;

        apb_transfer("status after reset", `APB_CTRL_ADDR, 1'b0, '0, status, err);
        check_value("status after reset", 32'h0, status);
        for (pos = 0; pos < prog_len; pos++)
            write_word("program load", `APB_IMEM_BASE + 12'(pos * 4), word_at(pos + 1), 1'b0);
        write_word("register window write", `APB_REG_BASE + 12'h004, 32'h1234, 1'b1);
        apb_transfer("unmapped read", 12'h400, 1'b0, '0, rdata, err);
        check_value("unmapped read pslverr", 32'd1, 32'(err));
        write_word("start", `APB_CTRL_ADDR, 32'h1, 1'b0);
        // halt word aimed at a mid program word not yet fetched
        write_word("imem write while running", `APB_IMEM_BASE + 12'(prog_len / 2 * 4),
                   {`OP_HALT, 26'd0}, 1'b1);

        status = '0;
        while (status[1] !== 1'b1)                 // wait for halted
            apb_transfer("status poll", `APB_CTRL_ADDR, 1'b0, '0, status, err);
        repeat (4) @(posedge SYS_clk);             // words ahead of halt retire
        apb_transfer("final status", `APB_CTRL_ADDR, 1'b0, '0, status, err);
        check_value("final status", word_at(prog_len + 2 + 2 * n_pairs), status);

        for (pos = 0; pos < n_pairs; pos++)
            order.push_back(pos);
        for (pos = n_pairs - 1; pos > 0; pos--)
        begin
            pick        = int'($urandom % (pos + 1));
            held        = order[pos];
            order[pos]  = order[pick];
            order[pick] = held;
        end
        foreach (order[k])
        begin
            idx = word_at(prog_len + 2 + 2 * order[k]);
            apb_transfer("register read", `APB_REG_BASE + 12'(idx * 4), 1'b0, '0, rdata, err);
            check_value($sformatf("register r%0d", idx),
                        word_at(prog_len + 3 + 2 * order[k]), rdata);
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* tb/core_testdata.txt */
// program length, program words, register check count,
// register index and expected value pairs, final status
18
20010006 20220007 00221820 00612022 // addi chain, add, sub
00642824 00643025 0083382A 2008FFFD // and, or, slt, addi -3
0101482A AC060008 8C0A0008 01415820 // slt signed, sw, lw, add after load
10820001 20050077 14220002 20060055 // beq taken, squashed, bne taken, squashed
20070066 10220001 216C0001 158B0001 // skipped, beq not taken, addi, bne on fwd
20010099 20200005 FC000000 20030044 // squashed, write r0, halt, after halt
0D
00 00000000
01 00000006
02 0000000D
03 00000013 // untouched by the word after halt
04 0000000D
05 00000001
06 0000001F
07 00000001
08 FFFFFFFD
09 00000001
0A 0000001F
0B 00000025
0C 00000026
3

/* tb.f */
+incdir+rtl
rtl/mips_pkg.sv
rtl/apb_host_port.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/hazard_unit.sv
rtl/execute_unit.sv
rtl/memwb_unit.sv
rtl/mips_core_top.sv
tb/mips_core_properties.sv
tb/tb_mips_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the MIPS core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_mips_core -Mdir obj_dir \
    || { echo "build failed"; exit 1; }
./obj_dir/Vtb_mips_core > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q -e "Errors found" -e "%Error" sim.log && { echo "FAILED"; exit 1; } || echo "PASSED"
